// File: flist.f
hdl/video_pkg.sv
hdl/cen_gen.sv
hdl/video_timing.sv
hdl/line_fetch.sv
hdl/line_buffer.sv
hdl/gcu_regs.sv
hdl/pixel_mixer.sv
hdl/arcade_video.sv
dv/tb_arcade_video.sv

// File: dv/tb_arcade_video.sv
// self-checking testbench with a fixed seed; the SDRAM model answers 1 to 4 cycles late and needs pxl_div 2
`timescale 1ns/1ps
`default_nettype none

module tb_arcade_video;
    import video_pkg::*;

    localparam int n_cfg = 10;
    localparam int max_cycles = 12 * v_total * h_total * pxl_div + 2000;

    logic        clk = 1'b0;
    logic        rst;
    apb_req_s    apb_req;
    apb_rsp_s    apb_rsp;
    rom_req_s    rom_req;
    rom_rsp_s    rom_rsp;
    sync_s       video_sync;
    rgb_t        rgb;
    logic        pxl_cen;
    logic        vs_out;

    // reference state of the registers
    rgb_t        pal_model [0:15];
    logic        disp_model;
    rom_addr_t   base_shadow;
    rom_addr_t   base_active;

    // monitor state
    sync_s       prev_sync;
    rgb_t        exp_rgb;
    int          x;
    int          vis_lines;
    int          hs_rises;
    int          vs_pixels;
    int          vs_count;
    int          frames_seen;
    int          frames_checked;
    int          cycles = 0;
    int          cen_gap = 0;
    logic        cen_seen = 1'b0;

    arcade_video u_dut (
        .clk     (clk),
        .rst     (rst),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .rom_req (rom_req),
        .rom_rsp (rom_rsp),
        .sync    (video_sync),
        .rgb     (rgb),
        .pxl_cen (pxl_cen)
    );

    assign vs_out = video_sync.vs;

    always #5 clk = ~clk;

    task automatic stop_with_failure();
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_rgb(input string name, input rgb_t exp, input rgb_t act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %06h actual %06h", name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_apb_data(input string name, input apb_data_t exp, input apb_data_t act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %08h actual %08h", name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %b actual %b", name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("MISMATCH %s expected %0d actual %0d", name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_reset_outputs();
        check_flag("rd in reset", 1'b0, rom_req.rd);
        check_flag("hs in reset", 1'b0, video_sync.hs);
        check_flag("vs in reset", 1'b0, video_sync.vs);
        check_flag("lhbl in reset", 1'b0, video_sync.lhbl);
        check_flag("lvbl in reset", 1'b0, video_sync.lvbl);
        check_flag("pslverr in reset", 1'b0, apb_rsp.pslverr);
        check_flag("pxl_cen in reset", 1'b0, pxl_cen);
        check_rgb("rgb in reset", '0, rgb);
    endtask

    // bank word is the low 16 bits of addr * 0x9e37 xor 0x5a5a
    function automatic rom_data_t bank_word(input rom_addr_t addr);
        return (addr[15:0] * 16'h9e37) ^ 16'h5a5a;
    endfunction

    function automatic pix_t expected_index(input rom_addr_t base, input int line, input int px);
        rom_addr_t addr;
        rom_data_t word;
        addr = base + rom_addr_t'(words_per_line * line + px / 4);
        word = bank_word(addr);
        return word[(px % 4) * 4 +: 4];
    endfunction

    // one setup cycle and one access cycle without wait states
    task automatic apb_xfer(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                            output apb_data_t rdata, output logic err);
        @(posedge clk);
        #1;
        apb_req.psel = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite = wr;
        apb_req.paddr = addr;
        apb_req.pwdata = wdata;
        @(posedge clk);
        #1;
        apb_req.penable = 1'b1;
        @(negedge clk);
        check_flag("apb pready in access cycle", 1'b1, apb_rsp.pready);
        rdata = apb_rsp.prdata;
        err = apb_rsp.pslverr;
        @(posedge clk);
        #1;
        apb_req = '0;
    endtask

    task automatic reg_write(input string name, input apb_addr_t addr, input apb_data_t wdata,
                             input logic exp_err);
        apb_data_t rdata;
        logic      err;
        apb_xfer(1'b1, addr, wdata, rdata, err);
        check_flag({name, " pslverr"}, exp_err, err);
    endtask

    task automatic reg_read(input string name, input apb_addr_t addr, input apb_data_t exp,
                            input logic exp_err);
        apb_data_t rdata;
        logic      err;
        apb_xfer(1'b0, addr, '0, rdata, err);
        check_apb_data(name, exp, rdata);
        check_flag({name, " pslverr"}, exp_err, err);
    endtask

    task automatic write_ctrl(input logic en);
        reg_write("ctrl write", reg_ctrl, apb_data_t'(en), 1'b0);
        disp_model = en;
    endtask

    // upper bits are random and must be dropped by the DUT
    task automatic write_tile_base(input apb_data_t wdata);
        reg_write("tile base write", reg_tile_base, wdata, 1'b0);
        base_shadow = wdata[21:0];
    endtask

    task automatic write_palette(input int idx, input rgb_t colour);
        reg_write("palette write", pal_base + apb_addr_t'(idx * 4), apb_data_t'(colour), 1'b0);
        pal_model[idx] = colour;
    endtask

    task automatic load_random_palette();
        for (int i = 0; i < 16; i++) begin
            write_palette(i, rgb_t'($urandom));
        end
    endtask

    task automatic register_access_test();
        logic en;
        int   idx;
        repeat (4) begin
            en = $urandom_range(0, 1);
            write_ctrl(en);
            reg_read("ctrl readback", reg_ctrl, apb_data_t'(en), 1'b0);
        end
        repeat (3) begin
            write_tile_base($urandom);
            reg_read("tile base readback", reg_tile_base, apb_data_t'(base_shadow), 1'b0);
        end
        repeat (6) begin
            idx = $urandom_range(0, 15);
            write_palette(idx, rgb_t'($urandom));
            reg_read("palette readback", pal_base + apb_addr_t'(idx * 4),
                     apb_data_t'(pal_model[idx]), 1'b0);
        end
        reg_read("status frame count", reg_status, apb_data_t'(vs_count[15:0]), 1'b0);
    endtask

    task automatic error_response_test();
        apb_addr_t bad_addr [0:4];
        // 0x42 is a misaligned palette offset
        bad_addr = '{8'h0c, 8'h3c, 8'h42, 8'h80, 8'hfc};
        for (int i = 0; i < 5; i++) begin
            reg_read("unmapped read", bad_addr[i], '0, 1'b1);
            reg_write("unmapped write", bad_addr[i], $urandom, 1'b1);
        end
        reg_write("status write", reg_status, $urandom, 1'b1);
        reg_read("status after errors", reg_status, apb_data_t'(vs_count[15:0]), 1'b0);
        reg_read("ctrl after errors", reg_ctrl, apb_data_t'(disp_model), 1'b0);
        reg_read("tile base after errors", reg_tile_base, apb_data_t'(base_shadow), 1'b0);
        reg_read("palette 0 after errors", pal_base, apb_data_t'(pal_model[0]), 1'b0);
        reg_read("palette 15 after errors", 8'h7c, apb_data_t'(pal_model[15]), 1'b0);
    endtask

    // SDRAM bank model with one request at a time
    initial begin
        rom_addr_t addr;
        int        ack_dly;
        int        dok_dly;
        rom_rsp = '0;
        forever begin
            @(negedge clk);
            if (!rst && rom_req.rd) begin
                addr = rom_req.addr;
                ack_dly = $urandom_range(1, 4);
                dok_dly = $urandom_range(1, 4);
                repeat (ack_dly) @(posedge clk);
                #1;
                rom_rsp.ack = 1'b1;
                @(negedge clk);
                check_flag("rom rd held until ack", 1'b1, rom_req.rd);
                check_flag("rom addr held until ack", 1'b1, rom_req.addr == addr);
                @(posedge clk);
                #1;
                rom_rsp.ack = 1'b0;
                repeat (dok_dly - 1) begin
                    @(posedge clk);
                    #1;
                end
                rom_rsp.dok = 1'b1;
                rom_rsp.data = bank_word(addr);
                @(posedge clk);
                #1;
                rom_rsp.dok = 1'b0;
            end
        end
    end

    // pixel enable spacing
    always @(negedge clk) begin
        if (!rst) begin
            cen_gap++;
            if (pxl_cen) begin
                if (cen_seen) begin
                    check_count("pxl_cen period", pxl_div, cen_gap);
                end
                cen_gap = 0;
                cen_seen = 1'b1;
            end
        end
    end

    // one sample per pixel in the enable cycle where outputs are settled
    always @(negedge clk) begin
        if (!rst && pxl_cen) begin
            if (video_sync.vs && !prev_sync.vs) begin
                if (frames_seen > 0) begin
                    check_count("visible lines per frame", v_active, vis_lines);
                    check_count("hs pulses per frame", v_total, hs_rises);
                    check_count("vs pixels per frame", vs_len * h_total, vs_pixels);
                    frames_checked++;
                end
                frames_seen++;
                vs_count++;
                base_active = base_shadow;
                vis_lines = 0;
                hs_rises = 0;
                vs_pixels = 0;
            end
            if (video_sync.vs) begin
                vs_pixels++;
            end
            if (video_sync.lhbl && !prev_sync.lhbl) begin
                if (frames_seen > 0) begin
                    check_count("pixels per line", h_total, x + 1);
                end
                x = 0;
                if (video_sync.lvbl) begin
                    vis_lines++;
                end
            end else begin
                x++;
            end
            // first line after reset is one pixel short
            if (frames_seen > 0) begin
                if (!video_sync.lhbl && prev_sync.lhbl) begin
                    check_count("visible pixels per line", h_active, x);
                end
                if (video_sync.hs && !prev_sync.hs) begin
                    check_count("hs start", hs_start, x);
                    hs_rises++;
                end
                if (!video_sync.hs && prev_sync.hs) begin
                    check_count("hs end", hs_start + hs_len, x);
                end
            end
            if (video_sync.lhbl && video_sync.lvbl && disp_model) begin
                exp_rgb = pal_model[expected_index(base_active, vis_lines - 1, x)];
            end else begin
                exp_rgb = '0;
            end
            check_rgb($sformatf("pixel x=%0d y=%0d", x, vis_lines - 1), exp_rgb, rgb);
            prev_sync = video_sync;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("run timed out after %0d clock cycles", cycles);
            stop_with_failure();
        end
    end

    initial begin
        apb_req = '0;
        rst = 1'b1;
        disp_model = 1'b0;
        base_shadow = '0;
        base_active = '0;
        prev_sync = '0;
        x = 0;
        vis_lines = 0;
        hs_rises = 0;
        vs_pixels = 0;
        vs_count = 0;
        frames_seen = 0;
        frames_checked = 0;
        void'($urandom(32'h4f29_ec20));
        repeat (4) @(posedge clk);
        @(negedge clk);
        check_reset_outputs();
        @(posedge clk);
        #1;
        rst = 1'b0;
        // all register traffic happens in vblank after vs falls
        for (int i = 0; i < n_cfg; i++) begin
            @(negedge vs_out);
            if (i == 0) begin
                register_access_test();
                load_random_palette();
                error_response_test();
            end else begin
                load_random_palette();
            end
            write_ctrl((i != 4) && (i != 7));
            if (i % 2 == 1) begin
                write_tile_base($urandom);
            end
            reg_read("status frame count", reg_status, apb_data_t'(vs_count[15:0]), 1'b0);
        end
        // let the last setting show for a whole frame
        @(negedge vs_out);
        if (frames_checked == n_cfg) begin
            $display("Regression passed");
            $finish;
        end else begin
            $display("only %0d of %0d frames were checked", frames_checked, n_cfg);
            stop_with_failure();
        end
    end

endmodule

`default_nettype wire

// File: hdl/arcade_video.sv
// tile layer only, one clock domain; the SDRAM port expects a single bank with rd/ack/dok
`timescale 1ns/1ps
`default_nettype none

module arcade_video (
    input  logic                clk,
    input  logic                rst,
    input  video_pkg::apb_req_s apb_req,
    output video_pkg::apb_rsp_s apb_rsp,
    output video_pkg::rom_req_s rom_req,
    input  video_pkg::rom_rsp_s rom_rsp,
    output video_pkg::sync_s    sync,
    output video_pkg::rgb_t     rgb,
    output logic                pxl_cen
);
    import video_pkg::*;

    hpos_t      h;
    vpos_t      v;
    sync_s      sync_raw;
    logic       line_start;
    logic       frame_start;
    rom_addr_t  tile_base;
    logic       display_en;
    logic       buf_we;
    logic       buf_wr_half;
    logic [3:0] buf_wr_word;
    rom_data_t  buf_wr_data;
    logic       buf_rd_half;
    logic [3:0] buf_rd_word;
    rom_data_t  buf_rd_data;
    pix_t       pal_idx;
    rgb_t       pal_rgb;

    cen_gen u_cen (
        .clk     (clk),
        .rst     (rst),
        .pxl_cen (pxl_cen)
    );

    video_timing u_timing (
        .clk         (clk),
        .rst         (rst),
        .pxl_cen     (pxl_cen),
        .h           (h),
        .v           (v),
        .sync        (sync_raw),
        .line_start  (line_start),
        .frame_start (frame_start)
    );

    // tile words for the next line
    line_fetch u_fetch (
        .clk        (clk),
        .rst        (rst),
        .line_start (line_start),
        .v          (v),
        .tile_base  (tile_base),
        .rom_req    (rom_req),
        .rom_rsp    (rom_rsp),
        .buf_we     (buf_we),
        .buf_half   (buf_wr_half),
        .buf_word   (buf_wr_word),
        .buf_data   (buf_wr_data)
    );

    line_buffer u_buf (
        .clk     (clk),
        .we      (buf_we),
        .wr_half (buf_wr_half),
        .wr_word (buf_wr_word),
        .wr_data (buf_wr_data),
        .rd_half (buf_rd_half),
        .rd_word (buf_rd_word),
        .rd_data (buf_rd_data)
    );

    gcu_regs u_regs (
        .clk         (clk),
        .rst         (rst),
        .apb_req     (apb_req),
        .apb_rsp     (apb_rsp),
        .frame_start (frame_start),
        .pal_idx     (pal_idx),
        .pal_rgb     (pal_rgb),
        .display_en  (display_en),
        .tile_base   (tile_base)
    );

    pixel_mixer u_mixer (
        .clk        (clk),
        .rst        (rst),
        .pxl_cen    (pxl_cen),
        .h          (h),
        .v          (v),
        .sync_in    (sync_raw),
        .buf_data   (buf_rd_data),
        .display_en (display_en),
        .pal_rgb    (pal_rgb),
        .buf_half   (buf_rd_half),
        .buf_word   (buf_rd_word),
        .pal_idx    (pal_idx),
        .sync_out   (sync),
        .rgb        (rgb)
    );

endmodule

`default_nettype wire

// File: hdl/pixel_mixer.sv
// colour and sync come out two pixel enables after h and v; needs pxl_div of 2 or more
`timescale 1ns/1ps
`default_nettype none

module pixel_mixer (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 pxl_cen,
    input  video_pkg::hpos_t     h,
    input  video_pkg::vpos_t     v,
    input  video_pkg::sync_s     sync_in,
    input  video_pkg::rom_data_t buf_data,
    input  logic                 display_en,
    input  video_pkg::rgb_t      pal_rgb,
    output logic                 buf_half,
    output logic [3:0]           buf_word,
    output video_pkg::pix_t      pal_idx,
    output video_pkg::sync_s     sync_out,
    output video_pkg::rgb_t      rgb
);
    import video_pkg::*;

    logic [1:0] nib;
    logic       vis;
    sync_s      sync_d;

    // stage 1: buffer address plus delayed nibble, visible and sync
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            buf_half <= v[0];
            buf_word <= h[5:2];
            nib <= h[1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            vis <= 1'b0;
            sync_d <= '0;
        end else if (pxl_cen) begin
            vis <= sync_in.lhbl && sync_in.lvbl;
            sync_d <= sync_in;
        end
    end

    // buffer word arrives one clk after the address, well before the next enable
    assign pal_idx = buf_data[{nib, 2'b00} +: 4];

    // stage 2: colour and sync leave together
    always_ff @(posedge clk) begin
        if (rst) begin
            rgb <= '0;
            sync_out <= '0;
        end else if (pxl_cen) begin
            rgb <= (vis && display_en) ? pal_rgb : '0;
            sync_out <= sync_d;
        end
    end

endmodule

`default_nettype wire

// File: hdl/gcu_regs.sv
// APB without wait states; palette writes are immediate so they belong in vblank
`timescale 1ns/1ps
`default_nettype none

module gcu_regs (
    input  logic                 clk,
    input  logic                 rst,
    input  video_pkg::apb_req_s  apb_req,
    output video_pkg::apb_rsp_s  apb_rsp,
    input  logic                 frame_start,
    input  video_pkg::pix_t      pal_idx,
    output video_pkg::rgb_t      pal_rgb,
    output logic                 display_en,
    output video_pkg::rom_addr_t tile_base
);
    import video_pkg::*;

    rgb_t        pal_mem [0:15];
    rom_addr_t   tile_shadow;
    logic [15:0] frame_cnt;
    logic        access;
    logic        pal_hit;
    logic        err;
    logic        wr_en;
    pix_t        pal_sel;
    apb_data_t   rd_val;

    always_comb begin
        access = apb_req.psel && apb_req.penable;
        // 0x40..0x7c, word aligned
        pal_hit = (apb_req.paddr[7:6] == pal_base[7:6]) && (apb_req.paddr[1:0] == 2'b00);
        pal_sel = apb_req.paddr[5:2];
        err = 1'b0;
        rd_val = '0;
        if (pal_hit) begin
            rd_val = {8'h00, pal_mem[pal_sel]};
        end else begin
            case (apb_req.paddr)
                reg_ctrl: rd_val = {31'b0, display_en};
                reg_tile_base: rd_val = apb_data_t'(tile_shadow);
                reg_status: begin
                    rd_val = {16'h0000, frame_cnt};
                    err = apb_req.pwrite;
                end
                default: err = 1'b1;
            endcase
        end
        wr_en = access && apb_req.pwrite && !err;
        apb_rsp.pready = access;
        apb_rsp.pslverr = access && err;
        apb_rsp.prdata = (access && !apb_req.pwrite) ? rd_val : '0;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            display_en <= 1'b0;
            tile_shadow <= '0;
            tile_base <= '0;
            frame_cnt <= '0;
        end else begin
            if (wr_en && !pal_hit && (apb_req.paddr == reg_ctrl)) begin
                display_en <= apb_req.pwdata[0];
            end
            if (wr_en && !pal_hit && (apb_req.paddr == reg_tile_base)) begin
                tile_shadow <= apb_req.pwdata[21:0];
            end
            // new base only at the top of the vs line
            if (frame_start) begin
                tile_base <= tile_shadow;
                frame_cnt <= frame_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en && pal_hit) begin
            pal_mem[pal_sel] <= apb_req.pwdata[23:0];
        end
    end

    // async read for the mixer
    assign pal_rgb = pal_mem[pal_idx];

endmodule

`default_nettype wire

// File: hdl/line_buffer.sv
// two 16-word halves, read data shows one clk after the read address
`timescale 1ns/1ps
`default_nettype none

module line_buffer (
    input  logic                 clk,
    input  logic                 we,
    input  logic                 wr_half,
    input  logic [3:0]           wr_word,
    input  video_pkg::rom_data_t wr_data,
    input  logic                 rd_half,
    input  logic [3:0]           rd_word,
    output video_pkg::rom_data_t rd_data
);
    import video_pkg::*;

    rom_data_t mem [0:31];

    // half select is the top address bit
    always_ff @(posedge clk) begin
        if (we) begin
            mem[{wr_half, wr_word}] <= wr_data;
        end
        rd_data <= mem[{rd_half, rd_word}];
    end

endmodule

`default_nettype wire

// File: hdl/line_fetch.sv
// one bank read in flight; a line_start that comes while a fetch is still running is ignored
`timescale 1ns/1ps
`default_nettype none

module line_fetch (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 line_start,
    input  video_pkg::vpos_t     v,
    input  video_pkg::rom_addr_t tile_base,
    output video_pkg::rom_req_s  rom_req,
    input  video_pkg::rom_rsp_s  rom_rsp,
    output logic                 buf_we,
    output logic                 buf_half,
    output logic [3:0]           buf_word,
    output video_pkg::rom_data_t buf_data
);
    import video_pkg::*;

    typedef enum logic [1:0] {
        idle,
        request,
        wait_ack,
        wait_data
    } state_t;

    state_t     state;
    vpos_t      next_line;
    vpos_t      line_n;
    logic [3:0] word;

    // line to be shown after the current one
    assign next_line = (v == vpos_t'(v_total - 1)) ? '0 : v + 1'b1;

    // dok words go straight into the buffer
    assign buf_we = (state == wait_data) && rom_rsp.dok;
    assign buf_half = line_n[0];
    assign buf_word = word;
    assign buf_data = rom_rsp.data;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
            rom_req.rd <= 1'b0;
            word <= '0;
        end else begin
            case (state)
                idle: begin
                    if (line_start && (next_line < vpos_t'(v_active))) begin
                        line_n <= next_line;
                        word <= '0;
                        state <= request;
                    end
                end
                request: begin
                    // 16n + k, since k is the low nibble
                    rom_req.addr <= tile_base + rom_addr_t'({line_n, word});
                    rom_req.rd <= 1'b1;
                    state <= wait_ack;
                end
                wait_ack: begin
                    if (rom_rsp.ack) begin
                        rom_req.rd <= 1'b0;
                        state <= wait_data;
                    end
                end
                wait_data: begin
                    if (rom_rsp.dok) begin
                        if (word == 4'(words_per_line - 1)) begin
                            state <= idle;
                        end else begin
                            word <= word + 1'b1;
                            state <= request;
                        end
                    end
                end
                default: state <= idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/video_timing.sv
// counters move on pxl_cen only; sync flags stay low until the first enable after reset
`timescale 1ns/1ps
`default_nettype none

module video_timing (
    input  logic            clk,
    input  logic            rst,
    input  logic            pxl_cen,
    output video_pkg::hpos_t h,
    output video_pkg::vpos_t v,
    output video_pkg::sync_s sync,
    output logic            line_start,
    output logic            frame_start
);
    import video_pkg::*;

    hpos_t h_nxt;
    vpos_t v_nxt;
    logic  h_wrap;

    always_comb begin
        h_wrap = (h == hpos_t'(h_total - 1));
        h_nxt = h_wrap ? '0 : h + 1'b1;
        v_nxt = v;
        if (h_wrap) begin
            v_nxt = (v == vpos_t'(v_total - 1)) ? '0 : v + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            h <= '0;
            v <= '0;
            sync <= '0;
            line_start <= 1'b0;
            frame_start <= 1'b0;
        end else begin
            // strobes land in the cycle where h already reads 0
            line_start <= pxl_cen && h_wrap;
            frame_start <= pxl_cen && h_wrap && (v_nxt == vpos_t'(vs_start));
            if (pxl_cen) begin
                h <= h_nxt;
                v <= v_nxt;
                // flags decoded from the next count so they line up with h and v
                sync.hs <= (h_nxt >= hpos_t'(hs_start)) &&
                           (h_nxt < hpos_t'(hs_start + hs_len));
                sync.vs <= (v_nxt >= vpos_t'(vs_start)) &&
                           (v_nxt < vpos_t'(vs_start + vs_len));
                sync.lhbl <= (h_nxt < hpos_t'(h_active));
                sync.lvbl <= (v_nxt < vpos_t'(v_active));
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/cen_gen.sv
// pixel enable is one clk in every pxl_div, first pulse comes pxl_div cycles after reset
`timescale 1ns/1ps
`default_nettype none

module cen_gen (
    input  logic clk,
    input  logic rst,
    output logic pxl_cen
);
    import video_pkg::*;

    logic [$clog2(pxl_div)-1:0] cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= '0;
            pxl_cen <= 1'b0;
        end else begin
            pxl_cen <= (cnt == pxl_div - 1);
            cnt <= (cnt == pxl_div - 1) ? '0 : cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: hdl/video_pkg.sv
// single-clock video constants and types; timing values are fixed and sized for 7-bit h and 6-bit v
`default_nettype none

package video_pkg;

    // clk cycles per pixel, must stay 2 or more for the buffer read latency
    localparam int pxl_div = 2;

    localparam int h_active = 64;
    localparam int h_total = 80;
    localparam int v_active = 48;
    localparam int v_total = 56;
    localparam int hs_start = 68;
    localparam int hs_len = 6;
    localparam int vs_start = 50;
    localparam int vs_len = 2;

    // 16-bit words with four 4-bit pixels each
    localparam int words_per_line = 16;

    typedef logic [6:0] hpos_t;
    typedef logic [5:0] vpos_t;
    typedef logic [21:0] rom_addr_t;
    typedef logic [15:0] rom_data_t;
    typedef logic [3:0] pix_t;
    typedef logic [23:0] rgb_t;
    typedef logic [7:0] apb_addr_t;
    typedef logic [31:0] apb_data_t;

    // register map, byte offsets
    localparam apb_addr_t reg_ctrl = 8'h00;
    localparam apb_addr_t reg_tile_base = 8'h04;
    localparam apb_addr_t reg_status = 8'h08;
    localparam apb_addr_t pal_base = 8'h40;

    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_addr_t paddr;
        apb_data_t pwdata;
    } apb_req_s;

    typedef struct packed {
        apb_data_t prdata;
        logic      pready;
        logic      pslverr;
    } apb_rsp_s;

    // lhbl and lvbl are high while visible
    typedef struct packed {
        logic hs;
        logic vs;
        logic lhbl;
        logic lvbl;
    } sync_s;

    typedef struct packed {
        rom_addr_t addr;
        logic      rd;
    } rom_req_s;

    typedef struct packed {
        logic      ack;
        logic      dok;
        rom_data_t data;
    } rom_rsp_s;

endpackage

`default_nettype wire
